// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int issue_num = 2;
	localparam int reg_num   = 32;

	// primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_addiu   = 6'h09;
	localparam logic [5:0] op_slti    = 6'h0a;
	localparam logic [5:0] op_andi    = 6'h0c;
	localparam logic [5:0] op_ori     = 6'h0d;
	localparam logic [5:0] op_xori    = 6'h0e;
	localparam logic [5:0] op_lui     = 6'h0f;

	// funct field of op_special
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	typedef enum logic [3:0] {
		alu_addu,
		alu_subu,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_lui
	} alu_op_t;

	// one word, two views picked by opcode
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			reg_addr_t  rs;
			reg_addr_t  rt;
			reg_addr_t  rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			reg_addr_t   rs;
			reg_addr_t   rt;
			logic [15:0] imm;
		} i;
	} instr_t;

	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		reg_addr_t rd;
		uint32_t   operand_a;
		uint32_t   operand_b;
	} issue_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		uint32_t   wdata;
	} result_t;

endpackage

`default_nettype wire

// File: issue_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface issue_bus_if;
	import cpu_pkg::*;

	// ID/EX contents, one entry per lane
	issue_t lanes [issue_num];

	modport decode (
		output lanes
	);

	modport exec (
		input lanes
	);

endinterface

`default_nettype wire

// File: wb_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface wb_bus_if;
	import cpu_pkg::*;

	result_t res [issue_num];

	// producer side
	modport exec (
		output res
	);

	// consumer side
	modport result (
		input res
	);

	// operand bypass
	modport fwd (
		input res
	);

endinterface

`default_nettype wire

// File: regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  wire logic                                     clk,
	input  wire logic                                     rst_n,
	wb_bus_if.result                                      wb,
	input  wire cpu_pkg::reg_addr_t [2*cpu_pkg::issue_num-1:0] raddr,
	output cpu_pkg::uint32_t        [2*cpu_pkg::issue_num-1:0] rdata
);
	import cpu_pkg::*;

	// r0 has no storage
	uint32_t regs [1:reg_num-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 1; r < reg_num; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int i = 0; i < issue_num; i++) begin
				if (wb.res[i].valid && wb.res[i].rd != '0) begin
					regs[wb.res[i].rd] <= wb.res[i].wdata;
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < 2*issue_num; k++) begin
			if (raddr[k] == '0) begin
				rdata[k] = '0;
			end else begin
				rdata[k] = regs[raddr[k]];
			end
		end
	end

endmodule

`default_nettype wire

// File: decode_and_issue.sv
`timescale 1ns/10ps
`default_nettype none

module decode_and_issue (
	input  wire logic                                     clk,
	input  wire logic                                     rst_n,
	input  wire logic [cpu_pkg::issue_num-1:0]            instr_valid,
	input  wire cpu_pkg::instr_t                          instr0,
	input  wire cpu_pkg::instr_t                          instr1,
	output logic                                          stall,
	output cpu_pkg::reg_addr_t [2*cpu_pkg::issue_num-1:0] raddr,
	input  wire cpu_pkg::uint32_t [2*cpu_pkg::issue_num-1:0] rdata,
	issue_bus_if.decode                                   issue,
	wb_bus_if.fwd                                         ex_fwd,
	wb_bus_if.fwd                                         wb_fwd
);
	import cpu_pkg::*;

	instr_t    instr      [issue_num];
	alu_op_t   op         [issue_num];
	reg_addr_t dst        [issue_num];
	uint32_t   imm        [issue_num];
	uint32_t   src_val    [2*issue_num];
	issue_t    next_issue [issue_num];
	issue_t    id_ex      [issue_num];

	logic [issue_num-1:0] known;
	logic [issue_num-1:0] reads_rs;
	logic [issue_num-1:0] reads_rt;
	logic [issue_num-1:0] shift;
	logic [issue_num-1:0] use_imm;
	logic [issue_num-1:0] lane_valid;
	logic [issue_num-1:0] issue_en;
	logic                 hazard;
	logic                 second_half;

	assign instr[0] = instr0;
	assign instr[1] = instr1;

	always_comb begin
		for (int i = 0; i < issue_num; i++) begin
			known[i]    = 1'b1;
			op[i]       = alu_addu;
			dst[i]      = instr[i].i.rt;
			reads_rs[i] = 1'b1;
			reads_rt[i] = 1'b0;
			shift[i]    = 1'b0;
			use_imm[i]  = 1'b1;
			imm[i]      = {{16{instr[i].i.imm[15]}}, instr[i].i.imm};
			raddr[2*i]   = instr[i].r.rs;
			raddr[2*i+1] = instr[i].r.rt;
			case (instr[i].i.opcode)
				op_special: begin
					dst[i]      = instr[i].r.rd;
					reads_rt[i] = 1'b1;
					use_imm[i]  = 1'b0;
					imm[i]      = {27'b0, instr[i].r.shamt};
					case (instr[i].r.funct)
						fn_addu: op[i] = alu_addu;
						fn_subu: op[i] = alu_subu;
						fn_and:  op[i] = alu_and;
						fn_or:   op[i] = alu_or;
						fn_xor:  op[i] = alu_xor;
						fn_slt:  op[i] = alu_slt;
						fn_sll, fn_srl: begin
							// value comes from rt, amount from shamt
							op[i]       = (instr[i].r.funct == fn_sll) ? alu_sll : alu_srl;
							shift[i]    = 1'b1;
							reads_rs[i] = 1'b0;
							use_imm[i]  = 1'b1;
						end
						default: known[i] = 1'b0;
					endcase
				end
				op_addiu: op[i] = alu_addu;
				op_slti:  op[i] = alu_slt;
				op_andi, op_ori, op_xori: begin
					imm[i] = {16'b0, instr[i].i.imm};
					if (instr[i].i.opcode == op_andi) begin
						op[i] = alu_and;
					end else if (instr[i].i.opcode == op_ori) begin
						op[i] = alu_or;
					end else begin
						op[i] = alu_xor;
					end
				end
				op_lui: begin
					op[i]       = alu_lui;
					reads_rs[i] = 1'b0;
					imm[i]      = {16'b0, instr[i].i.imm};
				end
				default: known[i] = 1'b0;
			endcase
		end
	end

	// bypass, ex over wb, lane 1 over lane 0
	always_comb begin
		for (int k = 0; k < 2*issue_num; k++) begin
			src_val[k] = rdata[k];
			if (raddr[k] != '0) begin
				for (int j = 0; j < issue_num; j++) begin
					if (wb_fwd.res[j].valid && wb_fwd.res[j].rd == raddr[k]) begin
						src_val[k] = wb_fwd.res[j].wdata;
					end
				end
				for (int j = 0; j < issue_num; j++) begin
					if (ex_fwd.res[j].valid && ex_fwd.res[j].rd == raddr[k]) begin
						src_val[k] = ex_fwd.res[j].wdata;
					end
				end
			end
		end
	end

	assign lane_valid = instr_valid & known;

	// lane 1 consumes lane 0's destination
	assign hazard = !second_half && lane_valid[0] && lane_valid[1] && dst[0] != '0
		&& ((reads_rs[1] && instr[1].r.rs == dst[0])
		|| (reads_rt[1] && instr[1].r.rt == dst[0]));

	assign stall       = hazard;
	assign issue_en[0] = !second_half;
	assign issue_en[1] = second_half || !hazard;

	always_comb begin
		for (int i = 0; i < issue_num; i++) begin
			next_issue[i].valid     = lane_valid[i] & issue_en[i];
			next_issue[i].op        = op[i];
			next_issue[i].rd        = dst[i];
			next_issue[i].operand_a = shift[i] ? src_val[2*i+1] : src_val[2*i];
			next_issue[i].operand_b = use_imm[i] ? imm[i] : src_val[2*i+1];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			second_half <= 1'b0;
			for (int i = 0; i < issue_num; i++) begin
				id_ex[i] <= '0;
			end
		end else begin
			second_half <= hazard;
			id_ex       <= next_issue;
		end
	end

	assign issue.lanes = id_ex;

endmodule

`default_nettype wire

// File: instr_exec.sv
`timescale 1ns/10ps
`default_nettype none

module instr_exec #(
	parameter int lane_idx = 0
) (
	issue_bus_if.exec lane,
	wb_bus_if.exec    result
);
	import cpu_pkg::*;

	issue_t  op_in;
	uint32_t a;
	uint32_t b;
	uint32_t wdata;

	assign op_in = lane.lanes[lane_idx];
	assign a     = op_in.operand_a;
	assign b     = op_in.operand_b;

	always_comb begin
		case (op_in.op)
			alu_addu: wdata = a + b;
			alu_subu: wdata = a - b;
			alu_and:  wdata = a & b;
			alu_or:   wdata = a | b;
			alu_xor:  wdata = a ^ b;
			// signed compare
			alu_slt:  wdata = {31'b0, $signed(a) < $signed(b)};
			alu_sll:  wdata = a << b[4:0];
			alu_srl:  wdata = a >> b[4:0];
			alu_lui:  wdata = {b[15:0], 16'h0000};
			default:  wdata = '0;
		endcase
	end

	assign result.res[lane_idx] = '{
		valid: op_in.valid,
		rd:    op_in.rd,
		wdata: wdata
	};

endmodule

`default_nettype wire

// File: write_back.sv
`timescale 1ns/10ps
`default_nettype none

module write_back (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	wb_bus_if.result                           ex,
	wb_bus_if.exec                             wb,
	output logic [cpu_pkg::issue_num-1:0]      retire_valid,
	output cpu_pkg::reg_addr_t                 retire_rd0,
	output cpu_pkg::reg_addr_t                 retire_rd1,
	output cpu_pkg::uint32_t                   retire_data0,
	output cpu_pkg::uint32_t                   retire_data1
);
	import cpu_pkg::*;

	result_t wb_q [issue_num];
	logic    drop_lane0;

	// EX/WB
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < issue_num; i++) begin
				wb_q[i] <= '0;
			end
		end else begin
			wb_q <= ex.res;
		end
	end

	// younger lane owns a shared destination
	assign drop_lane0 = wb_q[0].valid && wb_q[1].valid
		&& wb_q[0].rd == wb_q[1].rd && wb_q[0].rd != '0;

	assign wb.res[0] = '{
		valid: wb_q[0].valid & ~drop_lane0,
		rd:    wb_q[0].rd,
		wdata: wb_q[0].wdata
	};
	assign wb.res[1] = wb_q[1];

	assign retire_valid = {wb_q[1].valid, wb_q[0].valid};
	assign retire_rd0   = wb_q[0].rd;
	assign retire_rd1   = wb_q[1].rd;
	assign retire_data0 = wb_q[0].wdata;
	assign retire_data1 = wb_q[1].wdata;

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic [cpu_pkg::issue_num-1:0] instr_valid,
	input  wire cpu_pkg::instr_t               instr0,
	input  wire cpu_pkg::instr_t               instr1,
	output logic                               stall,
	output logic [cpu_pkg::issue_num-1:0]      retire_valid,
	output cpu_pkg::reg_addr_t                 retire_rd0,
	output cpu_pkg::reg_addr_t                 retire_rd1,
	output cpu_pkg::uint32_t                   retire_data0,
	output cpu_pkg::uint32_t                   retire_data1
);
	import cpu_pkg::*;

	reg_addr_t [2*issue_num-1:0] reg_raddr;
	uint32_t   [2*issue_num-1:0] reg_rdata;

	issue_bus_if issue_bus ();
	wb_bus_if    ex_bus ();
	wb_bus_if    wb_bus ();

	regfile regfile_inst (
		.clk,
		.rst_n,
		.wb    ( wb_bus    ),
		.raddr ( reg_raddr ),
		.rdata ( reg_rdata )
	);

	decode_and_issue decode_issue_inst (
		.clk,
		.rst_n,
		.instr_valid,
		.instr0,
		.instr1,
		.stall,
		.raddr  ( reg_raddr ),
		.rdata  ( reg_rdata ),
		.issue  ( issue_bus ),
		.ex_fwd ( ex_bus    ),
		.wb_fwd ( wb_bus    )
	);

	for (genvar i = 0; i < issue_num; i++) begin : gen_exec
		instr_exec #(
			.lane_idx ( i )
		) exec_inst (
			.lane   ( issue_bus ),
			.result ( ex_bus    )
		);
	end

	write_back write_back_inst (
		.clk,
		.rst_n,
		.ex ( ex_bus ),
		.wb ( wb_bus ),
		.retire_valid,
		.retire_rd0,
		.retire_rd1,
		.retire_data0,
		.retire_data1
	);

endmodule

`default_nettype wire

// File: tb_cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;
	import cpu_pkg::*;

	logic                 clk;
	logic                 rst_n;
	logic [issue_num-1:0] instr_valid;
	instr_t               instr0;
	instr_t               instr1;
	logic                 stall;
	logic [issue_num-1:0] retire_valid;
	reg_addr_t            retire_rd0;
	reg_addr_t            retire_rd1;
	uint32_t              retire_data0;
	uint32_t              retire_data1;

	uint32_t   model_regs [reg_num];
	uint32_t   lcg_state = 32'd49041;
	uint32_t   cyc = 0;
	string     cur_test;
	int        test_errors;
	int        n_errors = 0;
	int        n_tests = 0;
	reg_addr_t exp_rd [$];
	uint32_t   exp_data [$];
	uint32_t   exp_edge [$];
	reg_addr_t obs_rd [$];
	uint32_t   obs_data [$];
	uint32_t   obs_edge [$];

	cpu_core cpu_core_inst (
		.clk,
		.rst_n,
		.instr_valid,
		.instr0,
		.instr1,
		.stall,
		.retire_valid,
		.retire_rd0,
		.retire_rd1,
		.retire_data0,
		.retire_data1
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// collect retires in program order, lane 0 first
	always @(posedge clk) begin
		if (retire_valid[0]) begin
			obs_rd.push_back(retire_rd0);
			obs_data.push_back(retire_data0);
			obs_edge.push_back(cyc);
		end
		if (retire_valid[1]) begin
			obs_rd.push_back(retire_rd1);
			obs_data.push_back(retire_data1);
			obs_edge.push_back(cyc);
		end
	end

	function automatic uint32_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic instr_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
			reg_addr_t rd, logic [4:0] sh);
		return {op_special, rs, rt, rd, sh, fn};
	endfunction

	function automatic instr_t enc_i(logic [5:0] opc, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	// reference behavior of one instruction against the model registers
	function automatic void model_exec(input instr_t w, output logic ok,
			output reg_addr_t rd, output uint32_t val);
		uint32_t s;
		uint32_t t;
		uint32_t zimm;
		uint32_t simm;
		s    = model_regs[w.r.rs];
		t    = model_regs[w.r.rt];
		zimm = {16'h0000, w.i.imm};
		simm = {{16{w.i.imm[15]}}, w.i.imm};
		ok   = 1'b1;
		rd   = w.i.rt;
		val  = '0;
		case (w.i.opcode)
			op_special: begin
				rd = w.r.rd;
				case (w.r.funct)
					fn_addu: val = s + t;
					fn_subu: val = s - t;
					fn_and:  val = s & t;
					fn_or:   val = s | t;
					fn_xor:  val = s ^ t;
					fn_slt:  val = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
					fn_sll:  val = t << w.r.shamt;
					fn_srl:  val = t >> w.r.shamt;
					default: ok = 1'b0;
				endcase
			end
			op_addiu: val = s + simm;
			op_slti:  val = ($signed(s) < $signed(simm)) ? 32'd1 : 32'd0;
			op_andi:  val = s & zimm;
			op_ori:   val = s | zimm;
			op_xori:  val = s ^ zimm;
			op_lui:   val = {w.i.imm, 16'h0000};
			default:  ok = 1'b0;
		endcase
	endfunction

	function automatic logic reads_reg(instr_t w, reg_addr_t r);
		logic rs_used;
		logic rt_used;
		rs_used = (w.i.opcode != op_lui) && !(w.r.opcode == op_special
			&& (w.r.funct == fn_sll || w.r.funct == fn_srl));
		rt_used = (w.r.opcode == op_special);
		return (rs_used && w.r.rs == r) || (rt_used && w.r.rt == r);
	endfunction

	task automatic check_data(input string what, input uint32_t exp, input uint32_t act);
		if (exp !== act) begin
			$display("Fail %s (%s): expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_rd(input string what, input reg_addr_t exp, input reg_addr_t act);
		if (exp !== act) begin
			$display("Fail %s (%s): expected r%0d, actual r%0d", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
		n_tests++;
	endtask

	task automatic end_test();
		$display("test %s: %s (%0d errors)", cur_test,
			(test_errors == 0) ? "passed" : "failed", test_errors);
		n_errors += test_errors;
	endtask

	// drive one pair and hold it while stall is high
	task automatic send_pair(input logic [1:0] v, input instr_t w0, input instr_t w1);
		logic      ok0;
		logic      ok1;
		reg_addr_t rd0;
		reg_addr_t rd1;
		uint32_t   val0;
		uint32_t   val1;
		uint32_t   acc;
		int        exp_stalls;
		int        n;
		ok0 = 1'b0;
		ok1 = 1'b0;
		if (v[0]) begin
			model_exec(w0, ok0, rd0, val0);
			if (ok0 && rd0 != '0) begin
				model_regs[rd0] = val0;
			end
		end
		if (v[1]) begin
			model_exec(w1, ok1, rd1, val1);
			if (ok1 && rd1 != '0) begin
				model_regs[rd1] = val1;
			end
		end
		exp_stalls = (ok0 && ok1 && rd0 != '0 && reads_reg(w1, rd0)) ? 1 : 0;
		instr_valid <= v;
		instr0      <= w0;
		instr1      <= w1;
		@(posedge clk);
		acc = cyc;
		n   = 0;
		while (stall && n < 4) begin
			n++;
			@(posedge clk);
		end
		if (n == 4) begin
			$display("%s: stall stayed high for four cycles", cur_test);
			test_errors++;
		end
		check_data("stall cycles", exp_stalls, n);
		if (ok0) begin
			exp_rd.push_back(rd0);
			exp_data.push_back(val0);
			exp_edge.push_back(acc + 2);
		end
		if (ok1) begin
			exp_rd.push_back(rd1);
			exp_data.push_back(val1);
			exp_edge.push_back(acc + 2 + n);
		end
	endtask

	// idle the inputs and compare every retire with the model
	task automatic drain();
		int t;
		instr_valid <= '0;
		t = 0;
		while (obs_rd.size() < exp_rd.size() && t < 30) begin
			@(posedge clk);
			t++;
		end
		if (obs_rd.size() < exp_rd.size()) begin
			$display("%s: timed out waiting for retires", cur_test);
			test_errors++;
		end
		// room for stray retires to show up
		repeat (3) @(posedge clk);
		if (obs_rd.size() != exp_rd.size()) begin
			$display("%s: saw %0d retires where %0d were due", cur_test,
				obs_rd.size(), exp_rd.size());
			test_errors++;
		end
		while (obs_rd.size() > 0 && exp_rd.size() > 0) begin
			check_rd("retire rd", exp_rd.pop_front(), obs_rd.pop_front());
			check_data("retire data", exp_data.pop_front(), obs_data.pop_front());
			check_data("retire edge", exp_edge.pop_front(), obs_edge.pop_front());
		end
		exp_rd.delete();
		exp_data.delete();
		exp_edge.delete();
		obs_rd.delete();
		obs_data.delete();
		obs_edge.delete();
	endtask

	task automatic test_reset_imm();
		start_test("reset_imm");
		check_data("retire_valid after reset", '0, retire_valid);
		check_data("stall after reset", '0, stall);
		send_pair(2'b11, enc_i(op_lui, 5'd0, 5'd1, 16'h1234), enc_i(op_ori, 5'd0, 5'd2, 16'hbeef));
		send_pair(2'b11, enc_i(op_ori, 5'd1, 5'd1, 16'h5678), enc_i(op_lui, 5'd0, 5'd3, 16'hffff));
		drain();
		end_test();
	endtask

	task automatic test_alu();
		instr_t     words [14];
		logic [5:0] fns [8];
		logic [5:0] opcs [6];
		uint32_t    a;
		uint32_t    b;
		fns  = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sll, fn_srl};
		opcs = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
		start_test("alu_ops");
		for (int round = 0; round < 4; round++) begin
			a = lcg_next();
			b = lcg_next();
			send_pair(2'b11, enc_i(op_lui, 5'd0, 5'd4, a[31:16]),
				enc_i(op_lui, 5'd0, 5'd5, b[31:16]));
			send_pair(2'b11, enc_i(op_ori, 5'd4, 5'd4, a[15:0]),
				enc_i(op_ori, 5'd5, 5'd5, b[15:0]));
			for (int k = 0; k < 8; k++) begin
				words[k] = enc_r(fns[k], 5'd4, 5'd5, reg_addr_t'(10 + k), 5'(lcg_next() >> 27));
			end
			for (int k = 0; k < 6; k++) begin
				words[8+k] = enc_i(opcs[k], 5'd4, reg_addr_t'(20 + k), 16'(lcg_next() >> 16));
			end
			// odd rounds swap lanes
			for (int k = 0; k < 7; k++) begin
				if (round % 2 == 1) begin
					send_pair(2'b11, words[2*k+1], words[2*k]);
				end else begin
					send_pair(2'b11, words[2*k], words[2*k+1]);
				end
			end
			drain();
		end
		end_test();
	endtask

	task automatic test_forwarding();
		logic [15:0] imm1;
		logic [15:0] imm2;
		imm1 = 16'(lcg_next() >> 16);
		imm2 = 16'(lcg_next() >> 16);
		start_test("forwarding");
		send_pair(2'b11, enc_i(op_addiu, 5'd0, 5'd1, imm1), enc_i(op_addiu, 5'd0, 5'd2, imm2));
		send_pair(2'b11, enc_r(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0),
			enc_r(fn_xor, 5'd2, 5'd1, 5'd4, 5'd0));
		send_pair(2'b11, enc_r(fn_subu, 5'd3, 5'd1, 5'd5, 5'd0),
			enc_r(fn_or, 5'd4, 5'd2, 5'd6, 5'd0));
		send_pair(2'b11, enc_r(fn_addu, 5'd5, 5'd3, 5'd7, 5'd0),
			enc_r(fn_slt, 5'd6, 5'd4, 5'd8, 5'd0));
		drain();
		end_test();
	endtask

	task automatic test_pair_dependency();
		start_test("pair_dependency");
		send_pair(2'b11, enc_i(op_addiu, 5'd0, 5'd9, 16'd100),
			enc_r(fn_addu, 5'd9, 5'd9, 5'd10, 5'd0));
		send_pair(2'b11, enc_i(op_ori, 5'd0, 5'd11, 16'h00f0),
			enc_r(fn_sll, 5'd0, 5'd11, 5'd12, 5'd4));
		drain();
		end_test();
	endtask

	task automatic test_zero_same_dest();
		start_test("zero_same_dest");
		send_pair(2'b11, enc_i(op_addiu, 5'd0, 5'd0, 16'h1234),
			enc_r(fn_addu, 5'd0, 5'd0, 5'd13, 5'd0));
		send_pair(2'b11, enc_i(op_addiu, 5'd0, 5'd14, 16'd5),
			enc_i(op_addiu, 5'd0, 5'd14, 16'd9));
		send_pair(2'b11, enc_r(fn_addu, 5'd14, 5'd0, 5'd15, 5'd0),
			enc_r(fn_or, 5'd0, 5'd0, 5'd16, 5'd0));
		drain();
		// read back through the register file
		send_pair(2'b11, enc_r(fn_addu, 5'd14, 5'd0, 5'd17, 5'd0),
			enc_r(fn_addu, 5'd0, 5'd0, 5'd18, 5'd0));
		drain();
		end_test();
	endtask

	task automatic test_unknown();
		start_test("unknown_encoding");
		send_pair(2'b11, instr_t'(32'hfc000000), instr_t'(32'h0000003f));
		send_pair(2'b11, instr_t'(32'h7c000000), enc_i(op_addiu, 5'd0, 5'd18, 16'd7));
		send_pair(2'b11, enc_r(fn_addu, 5'd18, 5'd18, 5'd19, 5'd0),
			enc_i(op_ori, 5'd18, 5'd20, 16'd1));
		drain();
		end_test();
	endtask

	initial begin
		rst_n       = 1'b0;
		instr_valid = '0;
		instr0      = '0;
		instr1      = '0;
		for (int r = 0; r < reg_num; r++) begin
			model_regs[r] = '0;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset_imm();
		test_alu();
		test_forwarding();
		test_pair_dependency();
		test_zero_same_dest();
		test_unknown();
		$display("tests run %0d, errors %0d", n_tests, n_errors);
		if (n_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_core.f
cpu_pkg.sv
issue_bus_if.sv
wb_bus_if.sv
regfile.sv
decode_and_issue.sv
instr_exec.sv
write_back.sv
cpu_core.sv
tb_cpu_core.sv
